/* src/rv32_wb_pkg.sv */
package rv32_wb_pkg;

  // One architectural data word, shared by the integer and the single-precision files.
  typedef logic [31:0] word_t;

  // Register index into either 32-entry file.
  typedef logic [4:0] reg_idx_t;

  // Integer write-data select code as it comes out of the memory stage.
  typedef logic [2:0] w_sel_t;

  // Floating-point write-data select code.
  typedef logic [1:0] f_wsel_t;

  // Integer write-select codes.
  // Any code not listed here picks the pass-through reg_file_wdata word.
  localparam w_sel_t WSEL_LOAD = 3'd0;
  localparam w_sel_t WSEL_ALU  = 3'd3;
  localparam w_sel_t WSEL_CSR  = 3'd4;

  // Floating-point write-select codes.
  // Any other code picks the pass-through f_wdata word.
  localparam f_wsel_t FWSEL_FPU  = 2'd0;
  localparam f_wsel_t FWSEL_LOAD = 2'd1;

  // Both register files hold this many entries.
  localparam int NUM_REGS = 32;

  // Result bundle handed from the memory stage to writeback.
  // The integer and floating-point halves are independent and may both write in one cycle.
  typedef struct packed {
    logic     wen;
    reg_idx_t reg_rd;
    w_sel_t   w_sel;
    word_t    alu_port_out;
    word_t    dload_ext;
    word_t    csr_rdata;
    word_t    reg_file_wdata;
    logic     f_wen;
    reg_idx_t f_reg_rd;
    f_wsel_t  f_wsel;
    word_t    fpu_out;
    word_t    f_wdata;
  } mem_wb_t;

  // Writeback result as it is published for bypass into execute.
  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    word_t    rd_data;
    logic     f_wen;
    reg_idx_t f_rd;
    word_t    f_rd_data;
  } wb_bypass_t;

  // Source register indices requested by the execute stage.
  // The third floating-point source is only used by the fused multiply-add ops.
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t frs1;
    reg_idx_t frs2;
    reg_idx_t frs3;
  } src_req_t;

  // Resolved operand values returned to the execute stage.
  typedef struct packed {
    word_t rs1_data;
    word_t rs2_data;
    word_t frs1_data;
    word_t frs2_data;
    word_t frs3_data;
  } src_ops_t;

endpackage

/* src/pipe5_mem_wb_latch.sv */
`timescale 1ns/10ps

module pipe5_mem_wb_latch (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 stall,
  input  logic                 flush,
  input  rv32_wb_pkg::mem_wb_t mem_in,
  output rv32_wb_pkg::mem_wb_t mem_wb
);

  // The latch holds exactly one memory-stage bundle.
  // Only the two write flags carry control meaning.
  // The data fields are payload and are simply overwritten on the next capture.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      // Nothing may be written to either file coming out of reset.
      mem_wb.wen   <= 1'b0;
      mem_wb.f_wen <= 1'b0;
    end else if (flush) begin
      // A flush kills the entry even when a stall is raised in the same cycle.
      // The data fields stay as they were, since nothing downstream uses them
      // without a write flag set.
      mem_wb.wen   <= 1'b0;
      mem_wb.f_wen <= 1'b0;
    end else if (!stall) begin
      // Normal transfer takes the whole bundle from the memory stage.
      mem_wb <= mem_in;
    end
    // With stall alone, the held entry is kept unchanged.
    // It is rewritten to the files each cycle with the same value, which is harmless,
    // and its bypass stays visible to execute.
  end

  // After a flush or a reset edge, the writeback stage must see no write request.
  // This protects both register file write ports and both bypass flags.
  a_flags_clear_after_kill : assert property (
    @(posedge CLK)
      (!rst_n || flush) |=> (!mem_wb.wen && !mem_wb.f_wen)
  );

endmodule

/* src/pipe5_writeback_stage.sv */
`timescale 1ns/10ps

module pipe5_writeback_stage (
  input  rv32_wb_pkg::mem_wb_t    mem_wb,
  output logic                    rf_wen,
  output rv32_wb_pkg::reg_idx_t   rf_rd,
  output rv32_wb_pkg::word_t      rf_wdata,
  output logic                    frf_wen,
  output rv32_wb_pkg::reg_idx_t   frf_rd,
  output rv32_wb_pkg::word_t      frf_wdata,
  output rv32_wb_pkg::wb_bypass_t bypass
);

  import rv32_wb_pkg::*;

  // Selected write words for the two files.
  word_t w_data;
  word_t f_data;

  // Integer write data.
  // The ALU result is the common case, then loads, then CSR reads.
  // Every other code falls back to the pass-through word from memory.
  always_comb begin
    case (mem_wb.w_sel)
      WSEL_ALU:  w_data = mem_wb.alu_port_out;
      WSEL_LOAD: w_data = mem_wb.dload_ext;
      WSEL_CSR:  w_data = mem_wb.csr_rdata;
      default:   w_data = mem_wb.reg_file_wdata;
    endcase
  end

  // Floating-point write data.
  // FLW goes through the load path, FPU arithmetic through fpu_out,
  // and moves from the integer side come through f_wdata.
  always_comb begin
    case (mem_wb.f_wsel)
      FWSEL_FPU:  f_data = mem_wb.fpu_out;
      FWSEL_LOAD: f_data = mem_wb.dload_ext;
      default:    f_data = mem_wb.f_wdata;
    endcase
  end

  // Integer file write port.
  assign rf_wen   = mem_wb.wen;
  assign rf_rd    = mem_wb.reg_rd;
  assign rf_wdata = w_data;

  // Floating-point file write port.
  assign frf_wen   = mem_wb.f_wen;
  assign frf_rd    = mem_wb.f_reg_rd;
  assign frf_wdata = f_data;

  // The bypass takes the very same selected words as the write ports.
  // So a forwarded value always equals what lands in the file one edge later.
  assign bypass.wen       = mem_wb.wen;
  assign bypass.rd        = mem_wb.reg_rd;
  assign bypass.rd_data   = w_data;
  assign bypass.f_wen     = mem_wb.f_wen;
  assign bypass.f_rd      = mem_wb.f_reg_rd;
  assign bypass.f_rd_data = f_data;

endmodule

/* src/rv32i_reg_file.sv */
`timescale 1ns/10ps

module rv32i_reg_file (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  wen,
  input  rv32_wb_pkg::reg_idx_t rd,
  input  rv32_wb_pkg::word_t    wdata,
  input  rv32_wb_pkg::reg_idx_t rs1,
  input  rv32_wb_pkg::reg_idx_t rs2,
  output rv32_wb_pkg::word_t    rs1_data,
  output rv32_wb_pkg::word_t    rs2_data
);

  import rv32_wb_pkg::*;

  // Integer register storage for x0 through x31.
  word_t regs [NUM_REGS];

  // Single write port, written at the rising edge.
  // Entry 0 is cleared by reset and never written afterwards,
  // which is what makes x0 read as zero.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // Two combinational read ports.
  // A same-cycle write is not visible here; the forwarding unit covers that case.
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 must read zero on both ports at all times after reset,
  // whatever was attempted on the write port earlier.
  a_x0_reads_zero : assert property (
    @(posedge CLK) disable iff (!rst_n)
      ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0))
  );

endmodule

/* src/rv32f_reg_file.sv */
`timescale 1ns/10ps

module rv32f_reg_file (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  wen,
  input  rv32_wb_pkg::reg_idx_t rd,
  input  rv32_wb_pkg::word_t    wdata,
  input  rv32_wb_pkg::reg_idx_t rs1,
  input  rv32_wb_pkg::reg_idx_t rs2,
  input  rv32_wb_pkg::reg_idx_t rs3,
  output rv32_wb_pkg::word_t    rs1_data,
  output rv32_wb_pkg::word_t    rs2_data,
  output rv32_wb_pkg::word_t    rs3_data
);

  import rv32_wb_pkg::*;

  // Single-precision register storage for f0 through f31.
  // Unlike the integer file, f0 is an ordinary register.
  word_t regs [NUM_REGS];

  // Single write port at the rising edge.
  // All entries start from zero so that early reads are defined.
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[rd] <= wdata;
    end
  end

  // Three combinational read ports.
  // The third port serves the addend of the fused multiply-add instructions.
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];
  assign rs3_data = regs[rs3];

  // A write with an unknown index would corrupt an unpredictable register,
  // so the index coming out of the latch must be clean whenever wen is set.
  a_windex_known : assert property (
    @(posedge CLK) disable iff (!rst_n)
      wen |-> !$isunknown(rd)
  );

endmodule

/* src/pipe5_forwarding_unit.sv */
`timescale 1ns/10ps

module pipe5_forwarding_unit (
  input  rv32_wb_pkg::src_req_t   src,
  input  rv32_wb_pkg::wb_bypass_t bypass,
  input  rv32_wb_pkg::word_t      rs1_data,
  input  rv32_wb_pkg::word_t      rs2_data,
  input  rv32_wb_pkg::word_t      frs1_data,
  input  rv32_wb_pkg::word_t      frs2_data,
  input  rv32_wb_pkg::word_t      frs3_data,
  output rv32_wb_pkg::reg_idx_t   rs1,
  output rv32_wb_pkg::reg_idx_t   rs2,
  output rv32_wb_pkg::reg_idx_t   frs1,
  output rv32_wb_pkg::reg_idx_t   frs2,
  output rv32_wb_pkg::reg_idx_t   frs3,
  output rv32_wb_pkg::src_ops_t   ops
);

  import rv32_wb_pkg::*;

  // Integer operand select.
  // The writeback result wins over the file when it targets the same register.
  // x0 is never forwarded, so a discarded write to x0 cannot leak into execute.
  function automatic word_t fwd_int(reg_idx_t idx, word_t file_data, wb_bypass_t bp);
    word_t result;
    result = file_data;
    if (bp.wen && (idx == bp.rd) && (idx != '0)) begin
      result = bp.rd_data;
    end
    return result;
  endfunction

  // Floating-point operand select.
  // Same rule without the zero exception, because f0 holds real data.
  function automatic word_t fwd_fp(reg_idx_t idx, word_t file_data, wb_bypass_t bp);
    word_t result;
    result = file_data;
    if (bp.f_wen && (idx == bp.f_rd)) begin
      result = bp.f_rd_data;
    end
    return result;
  endfunction

  // The read indices go straight to the register files.
  // Their data returns combinationally in the same cycle.
  assign rs1  = src.rs1;
  assign rs2  = src.rs2;
  assign frs1 = src.frs1;
  assign frs2 = src.frs2;
  assign frs3 = src.frs3;

  // Resolve each operand against the single writeback result.
  // Only one stage sits behind execute here, so one bypass level is enough.
  assign ops.rs1_data  = fwd_int(src.rs1, rs1_data, bypass);
  assign ops.rs2_data  = fwd_int(src.rs2, rs2_data, bypass);
  assign ops.frs1_data = fwd_fp(src.frs1, frs1_data, bypass);
  assign ops.frs2_data = fwd_fp(src.frs2, frs2_data, bypass);
  assign ops.frs3_data = fwd_fp(src.frs3, frs3_data, bypass);

endmodule

/* src/pipe5_writeback_subsys.sv */
`timescale 1ns/10ps

module pipe5_writeback_subsys (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  rv32_wb_pkg::mem_wb_t  mem_in,
  input  logic                  stall,
  input  logic                  flush,
  input  rv32_wb_pkg::src_req_t src,
  output rv32_wb_pkg::src_ops_t ops
);

  import rv32_wb_pkg::*;

  // Entry held between memory and writeback.
  mem_wb_t mem_wb;

  // Integer file write port, driven by writeback.
  logic     rf_wen;
  reg_idx_t rf_rd;
  word_t    rf_wdata;

  // Floating-point file write port, driven by writeback.
  logic     frf_wen;
  reg_idx_t frf_rd;
  word_t    frf_wdata;

  // Writeback result offered to the forwarding unit.
  wb_bypass_t bypass;

  // Read indices from the forwarding unit and the raw data returned by the files.
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t frs1;
  reg_idx_t frs2;
  reg_idx_t frs3;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    frs1_data;
  word_t    frs2_data;
  word_t    frs3_data;

  // MEM/WB pipeline register with stall and flush.
  pipe5_mem_wb_latch i_mem_wb_latch (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .stall  (stall),
    .flush  (flush),
    .mem_in (mem_in),
    .mem_wb (mem_wb)
  );

  // Write-data selection for both files.
  pipe5_writeback_stage i_writeback_stage (
    .mem_wb    (mem_wb),
    .rf_wen    (rf_wen),
    .rf_rd     (rf_rd),
    .rf_wdata  (rf_wdata),
    .frf_wen   (frf_wen),
    .frf_rd    (frf_rd),
    .frf_wdata (frf_wdata),
    .bypass    (bypass)
  );

  // Integer registers, x0 hardwired to zero.
  rv32i_reg_file i_rv32i_reg_file (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .wen      (rf_wen),
    .rd       (rf_rd),
    .wdata    (rf_wdata),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // Single-precision registers with three read ports.
  rv32f_reg_file i_rv32f_reg_file (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .wen      (frf_wen),
    .rd       (frf_rd),
    .wdata    (frf_wdata),
    .rs1      (frs1),
    .rs2      (frs2),
    .rs3      (frs3),
    .rs1_data (frs1_data),
    .rs2_data (frs2_data),
    .rs3_data (frs3_data)
  );

  // Operand resolution for execute.
  pipe5_forwarding_unit i_forwarding_unit (
    .src       (src),
    .bypass    (bypass),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .frs1_data (frs1_data),
    .frs2_data (frs2_data),
    .frs3_data (frs3_data),
    .rs1       (rs1),
    .rs2       (rs2),
    .frs1      (frs1),
    .frs2      (frs2),
    .frs3      (frs3),
    .ops       (ops)
  );

endmodule

/* bench/tb_pipe5_writeback_subsys.sv */
`timescale 1ns/10ps

module tb_pipe5_writeback_subsys;

  import rv32_wb_pkg::*;

  // One table row holds the memory-stage bundle, the pipeline strobes and the execute request.
  typedef struct packed {
    mem_wb_t  mem;
    logic     stall;
    logic     flush;
    src_req_t src;
    logic     chk;
  } row_t;

  logic     CLK;
  logic     rst_n;
  mem_wb_t  mem_in;
  logic     stall;
  logic     flush;
  src_req_t src;
  src_ops_t ops;

  row_t    rows[$];
  integer  seed;
  int      fail_count;
  int      cycle_count;
  int      cycle_limit;

  // Reference state holds the shadow files and the entry the MEM/WB register should hold.
  word_t   shadow_i [NUM_REGS];
  word_t   shadow_f [NUM_REGS];
  mem_wb_t held;

  pipe5_writeback_subsys i_pipe5_writeback_subsys (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .mem_in (mem_in),
    .stall  (stall),
    .flush  (flush),
    .src    (src),
    .ops    (ops)
  );

  always #50 CLK = ~CLK;

  // Run guard sized from the reset length and the table length.
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles without finishing", cycle_limit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Appends one row; the six data words come from the seeded generator.
  task automatic add_row(input logic wen, input reg_idx_t rd, input w_sel_t ws,
                         input logic fwen, input reg_idx_t frd, input f_wsel_t fws,
                         input logic st, input logic fl,
                         input reg_idx_t s1, input reg_idx_t s2,
                         input reg_idx_t f1, input reg_idx_t f2, input reg_idx_t f3,
                         input logic chk);
    row_t r;
    r = '0;
    r.mem.wen            = wen;
    r.mem.reg_rd         = rd;
    r.mem.w_sel          = ws;
    r.mem.f_wen          = fwen;
    r.mem.f_reg_rd       = frd;
    r.mem.f_wsel         = fws;
    r.mem.alu_port_out   = $random(seed);
    r.mem.dload_ext      = $random(seed);
    r.mem.csr_rdata      = $random(seed);
    r.mem.reg_file_wdata = $random(seed);
    r.mem.fpu_out        = $random(seed);
    r.mem.f_wdata        = $random(seed);
    r.stall    = st;
    r.flush    = fl;
    r.src.rs1  = s1;
    r.src.rs2  = s2;
    r.src.frs1 = f1;
    r.src.frs2 = f2;
    r.src.frs3 = f3;
    r.chk      = chk;
    rows.push_back(r);
  endtask

  // Integer write word by select code; unlisted codes take the pass-through word.
  function automatic word_t int_write_word(mem_wb_t m);
    if (m.w_sel == WSEL_LOAD) return m.dload_ext;
    if (m.w_sel == WSEL_ALU) return m.alu_port_out;
    if (m.w_sel == WSEL_CSR) return m.csr_rdata;
    return m.reg_file_wdata;
  endfunction

  // Floating-point write word by select code.
  function automatic word_t fp_write_word(mem_wb_t m);
    if (m.f_wsel == FWSEL_FPU) return m.fpu_out;
    if (m.f_wsel == FWSEL_LOAD) return m.dload_ext;
    return m.f_wdata;
  endfunction

  // Expected integer operand: bypass first, except for x0, then the shadow file.
  function automatic word_t expect_int(reg_idx_t idx);
    if (held.wen && held.reg_rd == idx && idx != 5'd0) return int_write_word(held);
    return shadow_i[idx];
  endfunction

  // Expected floating-point operand; f0 forwards like any other register.
  function automatic word_t expect_fp(reg_idx_t idx);
    if (held.f_wen && held.f_reg_rd == idx) return fp_write_word(held);
    return shadow_f[idx];
  endfunction

  // Mirrors one rising edge.
  // The files take the held entry first, then the register updates.
  task automatic step_model();
    if (held.wen && held.reg_rd != 5'd0) shadow_i[held.reg_rd] = int_write_word(held);
    if (held.f_wen) shadow_f[held.f_reg_rd] = fp_write_word(held);
    if (flush) begin
      held.wen   = 1'b0;
      held.f_wen = 1'b0;
    end else if (!stall) begin
      held = mem_in;
    end
  endtask

  task automatic compare_operand(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      fail_count++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "operand mismatch");
    end
  endtask

  initial begin
    CLK         = 1'b0;
    rst_n       = 1'b0;
    mem_in      = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    src         = '0;
    seed        = 32'h8a8d722a;
    fail_count  = 0;
    cycle_count = 0;
    held        = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow_i[i] = '0;
      shadow_f[i] = '0;
    end

    // Row 0 reads straight after reset; rows 1 to 5 cover every select code.
    add_row(0, 5'd0, WSEL_ALU, 0, 5'd0, FWSEL_FPU, 0, 0, 5'd1, 5'd0, 5'd0, 5'd1, 5'd31, 1);
    add_row(1, 5'd1, WSEL_ALU, 1, 5'd1, FWSEL_FPU, 0, 0, 5'd5, 5'd6, 5'd2, 5'd3, 5'd4, 1);
    add_row(1, 5'd2, WSEL_LOAD, 1, 5'd2, FWSEL_LOAD, 0, 0, 5'd1, 5'd7, 5'd1, 5'd5, 5'd1, 1);
    add_row(1, 5'd3, WSEL_CSR, 1, 5'd3, 2'd2, 0, 0, 5'd1, 5'd2, 5'd1, 5'd2, 5'd8, 1);
    add_row(1, 5'd4, 3'd1, 1, 5'd4, 2'd3, 0, 0, 5'd3, 5'd2, 5'd3, 5'd3, 5'd3, 1);
    add_row(1, 5'd5, 3'd7, 0, 5'd5, FWSEL_FPU, 0, 0, 5'd4, 5'd3, 5'd4, 5'd4, 5'd4, 1);
    // Writes aimed at x0 and f0.
    add_row(1, 5'd0, WSEL_ALU, 1, 5'd0, FWSEL_FPU, 0, 0, 5'd5, 5'd0, 5'd4, 5'd0, 5'd1, 1);
    add_row(0, 5'd0, WSEL_ALU, 0, 5'd0, FWSEL_FPU, 0, 0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 1);
    add_row(0, 5'd0, WSEL_ALU, 0, 5'd0, FWSEL_FPU, 0, 0, 5'd0, 5'd1, 5'd0, 5'd2, 5'd0, 1);
    // Stall holds the x6/f6 entry for two edges while x7 and x8 are offered.
    add_row(1, 5'd6, WSEL_ALU, 1, 5'd6, FWSEL_FPU, 0, 0, 5'd6, 5'd0, 5'd6, 5'd0, 5'd0, 1);
    add_row(1, 5'd7, WSEL_ALU, 1, 5'd7, FWSEL_FPU, 1, 0, 5'd6, 5'd7, 5'd6, 5'd7, 5'd5, 1);
    add_row(1, 5'd8, WSEL_CSR, 1, 5'd8, FWSEL_LOAD, 1, 0, 5'd7, 5'd6, 5'd7, 5'd6, 5'd8, 1);
    add_row(1, 5'd9, WSEL_LOAD, 1, 5'd9, FWSEL_FPU, 0, 0, 5'd7, 5'd8, 5'd8, 5'd6, 5'd7, 1);
    // Flush alone, then stall and flush together.
    add_row(1, 5'd10, WSEL_ALU, 1, 5'd10, FWSEL_FPU, 0, 1, 5'd9, 5'd6, 5'd9, 5'd6, 5'd0, 1);
    add_row(1, 5'd14, WSEL_ALU, 1, 5'd14, FWSEL_LOAD, 0, 0, 5'd10, 5'd9, 5'd10, 5'd9, 5'd0, 1);
    add_row(1, 5'd11, WSEL_ALU, 1, 5'd11, FWSEL_FPU, 1, 1, 5'd10, 5'd14, 5'd14, 5'd10, 5'd9, 1);
    add_row(0, 5'd0, WSEL_ALU, 0, 5'd0, FWSEL_FPU, 0, 0, 5'd11, 5'd14, 5'd11, 5'd14, 5'd0, 1);
    // The x12 entry in writeback still lands when the capture behind it is flushed.
    add_row(1, 5'd12, WSEL_ALU, 1, 5'd12, FWSEL_FPU, 0, 0, 5'd11, 5'd1, 5'd11, 5'd1, 5'd2, 1);
    add_row(1, 5'd13, WSEL_ALU, 1, 5'd13, FWSEL_FPU, 0, 1, 5'd12, 5'd13, 5'd12, 5'd13, 5'd0, 1);
    add_row(0, 5'd0, WSEL_ALU, 0, 5'd0, FWSEL_FPU, 0, 0, 5'd12, 5'd13, 5'd12, 5'd13, 5'd0, 1);
    // The pass-through words in x4 and x5 are read back from the file.
    add_row(0, 5'd0, WSEL_ALU, 0, 5'd0, FWSEL_FPU, 0, 0, 5'd4, 5'd5, 5'd1, 5'd2, 5'd3, 1);

    cycle_limit = 16 + 2 * rows.size() + 20;

    repeat (16) @(posedge CLK);
    #10 rst_n = 1'b1;

    foreach (rows[i]) begin
      @(posedge CLK);
      // The model sees the same inputs that the DUT sampled at this edge.
      step_model();
      #10;
      mem_in = rows[i].mem;
      stall  = rows[i].stall;
      flush  = rows[i].flush;
      src    = rows[i].src;
      // Sample late in the cycle, well clear of both edges.
      #80;
      if (rows[i].chk) begin
        compare_operand("ops.rs1_data", ops.rs1_data, expect_int(src.rs1));
        compare_operand("ops.rs2_data", ops.rs2_data, expect_int(src.rs2));
        compare_operand("ops.frs1_data", ops.frs1_data, expect_fp(src.frs1));
        compare_operand("ops.frs2_data", ops.frs2_data, expect_fp(src.frs2));
        compare_operand("ops.frs3_data", ops.frs3_data, expect_fp(src.frs3));
      end
    end

    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
src/rv32_wb_pkg.sv
src/pipe5_mem_wb_latch.sv
src/pipe5_writeback_stage.sv
src/rv32i_reg_file.sv
src/rv32f_reg_file.sv
src/pipe5_forwarding_unit.sv
src/pipe5_writeback_subsys.sv
bench/tb_pipe5_writeback_subsys.sv

/* Bender.yml */
package:
  name: pipe5_writeback_subsys

sources:
  - src/rv32_wb_pkg.sv
  - src/pipe5_mem_wb_latch.sv
  - src/pipe5_writeback_stage.sv
  - src/rv32i_reg_file.sv
  - src/rv32f_reg_file.sv
  - src/pipe5_forwarding_unit.sv
  - src/pipe5_writeback_subsys.sv
  - target: simulation
    files:
      - bench/tb_pipe5_writeback_subsys.sv
